// File: logic/pool_defines.svh
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// Words per channel atom, one word per lane
`define POOL_BURST_LEN 8

// Signed data word on both buses
`define POOL_WORD_W 16

// Word address, shared by read and write bus
`define POOL_ADDR_W 30

// Largest window is 1 << POOL_MAX_KLOG2 atoms
`define POOL_MAX_KLOG2 2

// Lane accumulator holds a full window sum without overflow
`define POOL_ACC_W (`POOL_WORD_W + `POOL_MAX_KLOG2)

// Output atom count of one run
`define POOL_CNT_W 16

`endif

// File: logic/pool_pkg.sv
`include "pool_defines.svh"

package pool_pkg;

	typedef logic signed [`POOL_WORD_W-1:0] word_t;

	// Wide enough for the sum of the largest window
	typedef logic signed [`POOL_ACC_W-1:0] acc_t;

	// Lane 0 is the word at the lowest address
	typedef word_t atom_t [`POOL_BURST_LEN];

	typedef logic [`POOL_ADDR_W-1:0] addr_t;

	typedef logic [$clog2(`POOL_MAX_KLOG2 + 1)-1:0] klog2_t;

	typedef logic [`POOL_CNT_W-1:0] count_t;

	typedef enum logic [0:0] {
		POOL_MAX = 1'b0,
		POOL_AVG = 1'b1
	} pool_op_t;

endpackage

// File: logic/pool_fetch.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module pool_fetch (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,
	input  pool_pkg::addr_t    i_src_addr,
	input  pool_pkg::klog2_t   i_klog2,
	input  pool_pkg::count_t   i_count,
	input  pool_pkg::word_t    i_rd_dat,
	input  logic               i_rd_ack,
	input  logic               i_atom_ready,
	output logic               o_rd_cyc,
	output logic               o_rd_stb,
	output pool_pkg::addr_t    o_rd_adr,
	output logic               o_atom_valid,
	output pool_pkg::atom_t    o_atom
);

	localparam int LANE_W = $clog2(`POOL_BURST_LEN);
	localparam int TOT_W  = `POOL_CNT_W + `POOL_MAX_KLOG2 + LANE_W;

	logic                 stb_q;
	pool_pkg::addr_t      adr_q;
	logic [TOT_W-1:0]     left_q;    // Words still to read in this run
	logic [LANE_W-1:0]    lane_q;    // Lanes filled in the current atom
	logic                 valid_q;
	pool_pkg::atom_t      atom_q;
	logic                 take;
	logic                 issue;

	assign take = stb_q & i_rd_ack;

	// A new cycle needs a free lane register, or one that drains on this edge
	assign issue = ~stb_q & (left_q != '0) & (~valid_q | i_atom_ready);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stb_q   <= 1'b0;
			adr_q   <= '0;
			left_q  <= '0;
			lane_q  <= '0;
			valid_q <= 1'b0;
		end else if (i_start) begin
			stb_q   <= 1'b0;
			adr_q   <= i_src_addr;
			left_q  <= TOT_W'(i_count) << (i_klog2 + LANE_W);  // count * window * burst
			lane_q  <= '0;
			valid_q <= 1'b0;
		end else begin
			if (valid_q && i_atom_ready)
				valid_q <= 1'b0;

			if (take) begin
				stb_q  <= 1'b0;    // Idle at least one cycle between reads
				adr_q  <= adr_q + 1'b1;
				left_q <= left_q - 1'b1;
				lane_q <= lane_q + 1'b1;
				if (lane_q == LANE_W'(`POOL_BURST_LEN - 1)) begin
					lane_q  <= '0;
					valid_q <= 1'b1;  // Atom complete
				end
			end else if (issue) begin
				stb_q <= 1'b1;
			end
		end
	end

	// Deserializer
	// Each word enters at the top lane and moves down, so the
	// first word of a burst ends up in lane 0
	always_ff @(posedge clk) begin
		if (take) begin
			for (int l = 0; l < `POOL_BURST_LEN - 1; l++) begin
				atom_q[l] <= atom_q[l + 1];
			end
			atom_q[`POOL_BURST_LEN - 1] <= i_rd_dat;
		end
	end

	assign o_rd_cyc     = stb_q;
	assign o_rd_stb     = stb_q;
	assign o_rd_adr     = adr_q;
	assign o_atom_valid = valid_q;
	assign o_atom       = atom_q;

endmodule

// File: logic/pool_window.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module pool_window (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_start,
	input  pool_pkg::pool_op_t   i_op,
	input  pool_pkg::klog2_t     i_klog2,
	input  logic                 i_atom_valid,
	input  pool_pkg::atom_t      i_atom,
	input  logic                 i_result_ready,
	output logic                 o_atom_ready,
	output logic                 o_result_valid,
	output pool_pkg::atom_t      o_result
);

	localparam int WIN_W = `POOL_MAX_KLOG2;

	pool_pkg::pool_op_t   op_q;
	pool_pkg::klog2_t     klog2_q;
	logic [WIN_W-1:0]     win_q;       // Atom index inside the window
	logic                 res_valid_q;
	pool_pkg::acc_t       acc_q [`POOL_BURST_LEN];
	pool_pkg::acc_t       acc_nxt [`POOL_BURST_LEN];
	pool_pkg::atom_t      res_nxt;
	pool_pkg::atom_t      res_q;
	pool_pkg::klog2_t     shift;
	logic                 take;
	logic                 win_first;
	logic                 win_last;

	// Only one window in flight, so stall while a result waits
	assign o_atom_ready = ~res_valid_q;
	assign take         = i_atom_valid & ~res_valid_q;
	assign win_first    = (win_q == '0);
	assign win_last     = (win_q == WIN_W'((1 << klog2_q) - 1));
	assign shift        = (op_q == pool_pkg::POOL_AVG) ? klog2_q : '0;  // Max passes through

	always_comb begin
		pool_pkg::acc_t ext;
		pool_pkg::acc_t shf;
		for (int l = 0; l < `POOL_BURST_LEN; l++) begin
			ext = pool_pkg::acc_t'(i_atom[l]);  // Sign extend to accumulator width
			if (win_first)
				acc_nxt[l] = ext;
			else if (op_q == pool_pkg::POOL_MAX)
				acc_nxt[l] = (ext > acc_q[l]) ? ext : acc_q[l];
			else
				acc_nxt[l] = acc_q[l] + ext;

			// Arithmetic shift, so the average rounds toward minus infinity
			shf = acc_nxt[l] >>> shift;
			res_nxt[l] = shf[`POOL_WORD_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			op_q        <= pool_pkg::POOL_MAX;
			klog2_q     <= '0;
			win_q       <= '0;
			res_valid_q <= 1'b0;
		end else if (i_start) begin
			op_q        <= i_op;
			klog2_q     <= i_klog2;
			win_q       <= '0;
			res_valid_q <= 1'b0;
		end else begin
			if (res_valid_q && i_result_ready)
				res_valid_q <= 1'b0;
			if (take) begin
				win_q <= win_last ? '0 : win_q + 1'b1;
				if (win_last)
					res_valid_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			acc_q <= acc_nxt;
			if (win_last)
				res_q <= res_nxt;  // Held until writeback takes it
		end
	end

	assign o_result_valid = res_valid_q;
	assign o_result       = res_q;

endmodule

// File: logic/pool_writeback.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module pool_writeback (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,
	input  pool_pkg::addr_t    i_dst_addr,
	input  pool_pkg::count_t   i_count,
	input  logic               i_result_valid,
	input  pool_pkg::atom_t    i_result,
	input  logic               i_wr_ack,
	output logic               o_result_ready,
	output logic               o_wr_cyc,
	output logic               o_wr_stb,
	output logic               o_wr_we,
	output pool_pkg::addr_t    o_wr_adr,
	output pool_pkg::word_t    o_wr_dat,
	output logic               o_busy,
	output logic               o_done
);

	localparam int LANE_W = $clog2(`POOL_BURST_LEN);

	logic                 busy_q;
	logic                 done_q;
	logic                 hold_q;     // A result atom is being written
	logic                 stb_q;
	pool_pkg::count_t     left_q;     // Atoms still to write
	logic [LANE_W-1:0]    lane_q;
	pool_pkg::addr_t      adr_q;
	pool_pkg::atom_t      res_q;
	logic                 take_res;
	logic                 take_ack;
	logic                 last_lane;

	assign o_result_ready = ~hold_q;
	assign take_res       = i_result_valid & ~hold_q;
	assign take_ack       = stb_q & i_wr_ack;
	assign last_lane      = (lane_q == LANE_W'(`POOL_BURST_LEN - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			hold_q <= 1'b0;
			stb_q  <= 1'b0;
			left_q <= '0;
			lane_q <= '0;
			adr_q  <= '0;
		end else if (i_start) begin
			busy_q <= (i_count != '0);
			done_q <= (i_count == '0);  // An empty run ends at once
			hold_q <= 1'b0;
			stb_q  <= 1'b0;
			left_q <= i_count;
			lane_q <= '0;
			adr_q  <= i_dst_addr;
		end else begin
			done_q <= 1'b0;
			if (take_res) begin
				hold_q <= 1'b1;
				stb_q  <= 1'b1;    // First write in the next cycle
				lane_q <= '0;
			end else if (take_ack) begin
				stb_q  <= 1'b0;
				adr_q  <= adr_q + 1'b1;
				lane_q <= lane_q + 1'b1;
				if (last_lane) begin
					hold_q <= 1'b0;
					left_q <= left_q - 1'b1;
					// Last word of the last atom closes the run
					if (left_q == pool_pkg::count_t'(1)) begin
						busy_q <= 1'b0;
						done_q <= 1'b1;
					end
				end
			end else if (hold_q && !stb_q) begin
				stb_q <= 1'b1;     // Next lane after the idle cycle
			end
		end
	end

	// Local copy, so window can start on the next atom
	always_ff @(posedge clk) begin
		if (take_res)
			res_q <= i_result;
	end

	assign o_wr_cyc = stb_q;
	assign o_wr_stb = stb_q;
	assign o_wr_we  = stb_q;
	assign o_wr_adr = adr_q;
	assign o_wr_dat = res_q[lane_q];
	assign o_busy   = busy_q;
	assign o_done   = done_q;

endmodule

// File: logic/pool_engine.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module pool_engine (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_start,
	input  pool_pkg::pool_op_t   i_op,
	input  pool_pkg::klog2_t     i_klog2,
	input  pool_pkg::addr_t      i_src_addr,
	input  pool_pkg::addr_t      i_dst_addr,
	input  pool_pkg::count_t     i_count,
	input  pool_pkg::word_t      i_rd_dat,
	input  logic                 i_rd_ack,
	input  logic                 i_wr_ack,
	output logic                 o_busy,
	output logic                 o_done,
	output logic                 o_rd_cyc,
	output logic                 o_rd_stb,
	output pool_pkg::addr_t      o_rd_adr,
	output logic                 o_wr_cyc,
	output logic                 o_wr_stb,
	output logic                 o_wr_we,
	output pool_pkg::addr_t      o_wr_adr,
	output pool_pkg::word_t      o_wr_dat
);

	logic               start;
	logic               atom_valid;
	logic               atom_ready;
	pool_pkg::atom_t    atom;
	logic               result_valid;
	logic               result_ready;
	pool_pkg::atom_t    result;

	assign start = i_start & ~o_busy;  // A start during a run is dropped

	pool_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.i_start      (start),
		.i_src_addr   (i_src_addr),
		.i_klog2      (i_klog2),
		.i_count      (i_count),
		.i_rd_dat     (i_rd_dat),
		.i_rd_ack     (i_rd_ack),
		.i_atom_ready (atom_ready),
		.o_rd_cyc     (o_rd_cyc),
		.o_rd_stb     (o_rd_stb),
		.o_rd_adr     (o_rd_adr),
		.o_atom_valid (atom_valid),
		.o_atom       (atom)
	);

	pool_window u_window (
		.clk            (clk),
		.rst            (rst),
		.i_start        (start),
		.i_op           (i_op),
		.i_klog2        (i_klog2),
		.i_atom_valid   (atom_valid),
		.i_atom         (atom),
		.i_result_ready (result_ready),
		.o_atom_ready   (atom_ready),
		.o_result_valid (result_valid),
		.o_result       (result)
	);

	pool_writeback u_writeback (
		.clk            (clk),
		.rst            (rst),
		.i_start        (start),
		.i_dst_addr     (i_dst_addr),
		.i_count        (i_count),
		.i_result_valid (result_valid),
		.i_result       (result),
		.i_wr_ack       (i_wr_ack),
		.o_result_ready (result_ready),
		.o_wr_cyc       (o_wr_cyc),
		.o_wr_stb       (o_wr_stb),
		.o_wr_we        (o_wr_we),
		.o_wr_adr       (o_wr_adr),
		.o_wr_dat       (o_wr_dat),
		.o_busy         (o_busy),
		.o_done         (o_done)
	);

endmodule

// File: test/tb_memory.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module tb_memory #(
	parameter int WORDS = 1024
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_rd_cyc,
	input  logic               i_rd_stb,
	input  pool_pkg::addr_t    i_rd_adr,
	output pool_pkg::word_t    o_rd_dat,
	output logic               o_rd_ack,
	input  logic               i_wr_cyc,
	input  logic               i_wr_stb,
	input  logic               i_wr_we,
	input  pool_pkg::addr_t    i_wr_adr,
	input  pool_pkg::word_t    i_wr_dat,
	output logic               o_wr_ack,
	input  logic               i_load_en,     // Backdoor load from the testbench
	input  pool_pkg::addr_t    i_load_adr,
	input  pool_pkg::word_t    i_load_dat
);

	localparam int IDX_W = $clog2(WORDS);

	pool_pkg::word_t   mem [WORDS];
	logic              rd_armed;
	logic              wr_armed;
	logic [1:0]        rd_wait;
	logic [1:0]        wr_wait;
	logic [1:0]        draw;
	logic              rd_go;
	logic              wr_go;

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			o_rd_ack <= 1'b0;
			o_wr_ack <= 1'b0;
			rd_armed <= 1'b0;
			wr_armed <= 1'b0;
			rd_wait  <= '0;
			wr_wait  <= '0;
		end else begin
			o_rd_ack <= 1'b0;
			o_wr_ack <= 1'b0;
			rd_go = 1'b0;
			wr_go = 1'b0;

			// Each access draws its own wait of 0 to 3 cycles
			if (i_rd_cyc && i_rd_stb && !o_rd_ack) begin
				if (!rd_armed) begin
					draw = 2'($urandom_range(3, 0));
					rd_go = (draw == 2'd0);
					rd_armed <= (draw != 2'd0);
					rd_wait  <= draw - 2'd1;
				end else begin
					rd_go = (rd_wait == 2'd0);
					rd_armed <= (rd_wait != 2'd0);
					rd_wait  <= rd_wait - 2'd1;
				end
			end
			if (rd_go) begin
				o_rd_ack <= 1'b1;
				o_rd_dat <= mem[i_rd_adr[IDX_W-1:0]];
			end

			if (i_wr_cyc && i_wr_stb && i_wr_we && !o_wr_ack) begin
				if (!wr_armed) begin
					draw = 2'($urandom_range(3, 0));
					wr_go = (draw == 2'd0);
					wr_armed <= (draw != 2'd0);
					wr_wait  <= draw - 2'd1;
				end else begin
					wr_go = (wr_wait == 2'd0);
					wr_armed <= (wr_wait != 2'd0);
					wr_wait  <= wr_wait - 2'd1;
				end
			end
			if (wr_go) begin
				o_wr_ack <= 1'b1;
				mem[i_wr_adr[IDX_W-1:0]] <= i_wr_dat;  // Word lands with the ack
			end

			if (i_load_en)
				mem[i_load_adr[IDX_W-1:0]] <= i_load_dat;
		end
	end

endmodule

// File: test/tb_pool_engine.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module tb_pool_engine;

	localparam int MEM_WORDS = 1024;
	localparam int BURST     = `POOL_BURST_LEN;
	localparam int RUN_LIMIT = 1000;    // Cycles from start to o_done
	// Words read plus words written over all runs
	localparam int BUS_WORDS = (48 + 24) + (64 + 16) + 2 * (32 + 32) + (32 + 16)
		+ (48 + 24) + (64 + 16);
	localparam int CYCLE_LIMIT = 5 * BUS_WORDS + 1000;

	logic                 clk;
	logic                 rst;
	logic                 start;
	pool_pkg::pool_op_t   op;
	pool_pkg::klog2_t     klog2;
	pool_pkg::addr_t      src_addr;
	pool_pkg::addr_t      dst_addr;
	pool_pkg::count_t     count;
	pool_pkg::word_t      rd_dat;
	logic                 rd_ack;
	logic                 wr_ack;
	logic                 busy;
	logic                 done;
	logic                 rd_cyc;
	logic                 rd_stb;
	pool_pkg::addr_t      rd_adr;
	logic                 wr_cyc;
	logic                 wr_stb;
	logic                 wr_we;
	pool_pkg::addr_t      wr_adr;
	pool_pkg::word_t      wr_dat;
	logic                 load_en;
	pool_pkg::addr_t      load_adr;
	pool_pkg::word_t      load_dat;
	pool_pkg::word_t      image [MEM_WORDS];  // Words the testbench put into memory
	int                   errors;
	int                   done_pulses;
	int                   cycle;

	pool_engine dut (
		.clk (clk), .rst (rst), .i_start (start), .i_op (op), .i_klog2 (klog2),
		.i_src_addr (src_addr), .i_dst_addr (dst_addr), .i_count (count),
		.i_rd_dat (rd_dat), .i_rd_ack (rd_ack), .i_wr_ack (wr_ack),
		.o_busy (busy), .o_done (done), .o_rd_cyc (rd_cyc), .o_rd_stb (rd_stb),
		.o_rd_adr (rd_adr), .o_wr_cyc (wr_cyc), .o_wr_stb (wr_stb), .o_wr_we (wr_we),
		.o_wr_adr (wr_adr), .o_wr_dat (wr_dat)
	);

	tb_memory #(.WORDS(MEM_WORDS)) mem_model (
		.clk (clk), .rst (rst), .i_rd_cyc (rd_cyc), .i_rd_stb (rd_stb),
		.i_rd_adr (rd_adr), .o_rd_dat (rd_dat), .o_rd_ack (rd_ack),
		.i_wr_cyc (wr_cyc), .i_wr_stb (wr_stb), .i_wr_we (wr_we), .i_wr_adr (wr_adr),
		.i_wr_dat (wr_dat), .o_wr_ack (wr_ack), .i_load_en (load_en),
		.i_load_adr (load_adr), .i_load_dat (load_dat)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		for (cycle = 0; cycle < CYCLE_LIMIT; cycle++)
			@(posedge clk);
		$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	always @(posedge clk or posedge rst) begin
		if (rst)
			done_pulses <= 0;
		else if (done)
			done_pulses <= done_pulses + 1;
	end

	task automatic check_word(input string name, input pool_pkg::word_t got,
		input pool_pkg::word_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic load_word(input int addr, input pool_pkg::word_t data);
		@(negedge clk);
		load_en  = 1'b1;
		load_adr = pool_pkg::addr_t'(addr);
		load_dat = data;
		image[addr] = data;
	endtask

	task automatic stop_load();
		@(negedge clk);
		load_en = 1'b0;
	endtask

	task automatic fill_random(input int base, input int n);
		for (int i = 0; i < n; i++)
			load_word(base + i, pool_pkg::word_t'($urandom));
		stop_load();
	endtask

	// Marker tied to the address shows any stray write
	task automatic fill_marker(input int base, input int n);
		for (int i = 0; i < n; i++)
			load_word(base + i, pool_pkg::word_t'(16'ha5c3 ^ 16'(base + i)));
		stop_load();
	endtask

	task automatic pulse_start(input pool_pkg::pool_op_t o, input int k, input int src,
		input int dst, input int n);
		@(negedge clk);
		start    = 1'b1;
		op       = o;
		klog2    = pool_pkg::klog2_t'(k);
		src_addr = pool_pkg::addr_t'(src);
		dst_addr = pool_pkg::addr_t'(dst);
		count    = pool_pkg::count_t'(n);
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!done && n < RUN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			errors++;
			$display("o_done did not pulse within %0d cycles of the start", RUN_LIMIT);
		end else begin
			check_flag("o_busy", busy, 1'b0);  // Falls together with done
		end
	endtask

	// Lane result over non-overlapping windows of 1 << k atoms
	function automatic pool_pkg::word_t expected_word(input pool_pkg::pool_op_t o,
		input int k, input int src, input int atom, input int lane);
		int win;
		int acc;
		int v;
		win = 1 << k;
		acc = 0;
		for (int w = 0; w < win; w++) begin
			v = int'(image[src + (atom * win + w) * BURST + lane]);
			if (w == 0)
				acc = v;
			else if (o == pool_pkg::POOL_MAX)
				acc = (v > acc) ? v : acc;
			else
				acc = acc + v;
		end
		if (o == pool_pkg::POOL_AVG)
			acc = acc >>> k;   // Floor of the mean
		return pool_pkg::word_t'(acc);
	endfunction

	task automatic verify_pooled(input pool_pkg::pool_op_t o, input int k, input int src,
		input int dst, input int n);
		int a;
		for (int j = 0; j < n; j++) begin
			for (int l = 0; l < BURST; l++) begin
				a = dst + j * BURST + l;
				check_word($sformatf("mem[%0d]", a), mem_model.mem[a],
					expected_word(o, k, src, j, l));
			end
		end
		a = dst + n * BURST;
		check_word($sformatf("mem[%0d] past the result", a), mem_model.mem[a], image[a]);
	endtask

	task automatic expect_untouched(input int base, input int n);
		for (int a = base; a < base + n; a++)
			check_word($sformatf("mem[%0d]", a), mem_model.mem[a], image[a]);
	endtask

	task automatic run_pool(input pool_pkg::pool_op_t o, input int k, input int src,
		input int dst, input int n);
		pulse_start(o, k, src, dst, n);
		wait_done();
		verify_pooled(o, k, src, dst, n);
	endtask

	task automatic reset_state_idle();
		check_flag("o_busy", busy, 1'b0);
		check_flag("o_done", done, 1'b0);
		check_flag("o_rd_cyc", rd_cyc, 1'b0);
		check_flag("o_wr_cyc", wr_cyc, 1'b0);
		fill_marker(600, 16);
		repeat (20) begin
			@(negedge clk);
			check_flag("o_wr_cyc", wr_cyc, 1'b0);
		end
		expect_untouched(600, 16);
	endtask

	task automatic max_pool_window2();
		fill_random(0, 48);
		fill_marker(300, 32);
		run_pool(pool_pkg::POOL_MAX, 1, 0, 300, 3);
	endtask

	// Full-scale lanes make the window sum need the two extra bits
	task automatic avg_pool_extremes();
		pool_pkg::word_t v;
		for (int i = 0; i < 64; i++) begin
			case (i % BURST)
				0, 1: v = 16'sh7fff;
				2, 3: v = 16'sh8000;
				4: v = ((i / BURST) % 2 == 1) ? 16'sh8000 : 16'sh7fff;
				default: v = pool_pkg::word_t'($urandom);
			endcase
			load_word(64 + i, v);
		end
		stop_load();
		fill_marker(340, 24);
		run_pool(pool_pkg::POOL_AVG, 2, 64, 340, 2);
	endtask

	task automatic window_one_copy();
		fill_random(128, 32);
		fill_marker(380, 40);
		run_pool(pool_pkg::POOL_MAX, 0, 128, 380, 4);
		fill_random(128, 32);
		fill_marker(380, 40);
		run_pool(pool_pkg::POOL_AVG, 0, 128, 380, 4);
	endtask

	task automatic start_while_busy();
		int pulses_at_start;
		fill_random(200, 32);
		fill_marker(440, 24);
		fill_marker(480, 24);
		pulses_at_start = done_pulses;
		pulse_start(pool_pkg::POOL_MAX, 1, 200, 440, 2);
		repeat (3) @(negedge clk);
		check_flag("o_busy", busy, 1'b1);
		pulse_start(pool_pkg::POOL_AVG, 0, 0, 480, 2);  // Must be dropped
		wait_done();
		verify_pooled(pool_pkg::POOL_MAX, 1, 200, 440, 2);
		repeat (20) @(negedge clk);
		check_flag("o_busy", busy, 1'b0);
		expect_untouched(480, 24);
		if (done_pulses - pulses_at_start != 1) begin
			errors++;
			$display("o_done pulsed %0d times for a single run",
				done_pulses - pulses_at_start);
		end
	endtask

	task automatic back_to_back_runs();
		fill_random(512, 48);
		fill_random(560, 64);
		fill_marker(700, 32);
		fill_marker(740, 24);
		run_pool(pool_pkg::POOL_MAX, 1, 512, 700, 3);
		run_pool(pool_pkg::POOL_AVG, 2, 560, 740, 2);
	endtask

	initial begin
		void'($urandom(32'hf35a5b43));
		errors   = 0;
		rst      = 1'b1;
		start    = 1'b0;
		op       = pool_pkg::POOL_MAX;
		klog2    = '0;
		src_addr = '0;
		dst_addr = '0;
		count    = '0;
		load_en  = 1'b0;
		load_adr = '0;
		load_dat = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		reset_state_idle();
		max_pool_window2();
		avg_pool_extremes();
		window_one_copy();
		start_while_busy();
		back_to_back_runs();

		$display("Checks finished with %0d errors and %0d o_done pulses", errors, done_pulses);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+logic
logic/pool_pkg.sv
logic/pool_fetch.sv
logic/pool_window.sv
logic/pool_writeback.sv
logic/pool_engine.sv
test/tb_memory.sv
test/tb_pool_engine.sv

// File: Makefile
TOP = tb_pool_engine
RTL = logic/pool_pkg.sv logic/pool_fetch.sv logic/pool_window.sv \
      logic/pool_writeback.sv logic/pool_engine.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+logic $(RTL) --top-module pool_engine
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o sim_pool
	./obj_dir/sim_pool | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
